/* design/exeSettings.svh */
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// integer register and data path width
`define XLEN 32

`define CSR_ADDR_W 12 // csr address space
`define REG_ADDR_W 5  // x0..x31

`endif

/* design/rvOpsPkg.sv */
`include "exeSettings.svh"

package rvOpsPkg;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} aluOp_t;

	typedef enum logic [1:0] {
		MUL_NONE  = 2'd0,
		MUL_MUL   = 2'd1, // low word
		MUL_MULH  = 2'd2, // signed x signed, high word
		MUL_MULHU = 2'd3  // unsigned x unsigned, high word
	} mulOp_t;

	// register write-back source
	typedef enum logic [2:0] {
		WB_ALU   = 3'd0,
		WB_LINK  = 3'd1, // pc+4
		WB_MUL   = 3'd2,
		WB_LUI   = 3'd3,
		WB_AUIPC = 3'd4, // uImm+pc
		WB_CSR   = 3'd5
	} wbSel_t;

	typedef enum logic [2:0] {
		CSR_NONE = 3'd0,
		CSR_RW   = 3'd1,
		CSR_RS   = 3'd2,
		CSR_RC   = 3'd3,
		CSR_RWI  = 3'd5,
		CSR_RSI  = 3'd6,
		CSR_RCI  = 3'd7
	} csrOp_t;

endpackage

/* design/trapPkg.sv */
`include "exeSettings.svh"

package trapPkg;

	typedef enum logic [1:0] {
		PRIV_U = 2'd0,
		PRIV_S = 2'd1,
		PRIV_M = 2'd3
	} privMode_t;

	// mcause code field, top bit of the word left out
	typedef enum logic [`XLEN-2:0] {
		I_ADDR_MISALIGNED = 0,
		I_ILLEGAL         = 2,
		S_INT_TIMER       = 5,
		M_INT_TIMER       = 7,
		U_CALL            = 8,  // S and M calls follow at +1 and +3
		S_INT_EXT         = 9,
		M_INT_EXT         = 11
	} excCode_t;

	typedef struct packed {
		logic     intr; // set for interrupts
		excCode_t code;
	} causeFields_t;

	// raw word for the csr file, fields for the trap logic
	typedef union packed {
		logic [`XLEN-1:0] raw;
		causeFields_t     f;
	} cause_t;

endpackage

/* design/exeIfs.sv */
`timescale 1ns/1ps
`include "exeSettings.svh"

// stage-6 integer result towards commit
interface intResIf;
	logic                   valid;
	logic [`REG_ADDR_W-1:0] rd;
	logic                   regWe;
	logic [`XLEN-1:0]       result; // already muxed by wbSel
	logic                   isCsr;  // take csrOld instead

	modport source (output valid, rd, regWe, result, isCsr);
	modport sink (input valid, rd, regWe, result, isCsr);
endinterface

// stage-6 csr and trap result towards commit
interface trapResIf import trapPkg::*;;
	logic [`XLEN-1:0]       csrOld;
	logic [`XLEN-1:0]       csrNew;
	logic [`CSR_ADDR_W-1:0] csrAddr;
	logic                   csrWe;
	logic                   trapReq;
	cause_t                 cause;
	logic                   mret;
	logic [`XLEN-1:0]       pc;

	modport source (
		output csrOld, csrNew, csrAddr, csrWe, trapReq, cause, mret, pc
	);
	modport sink (
		input csrOld, csrNew, csrAddr, csrWe, trapReq, cause, mret, pc
	);
endinterface

/* design/intExecUnit.sv */
`timescale 1ns/1ps
`include "exeSettings.svh"

module intExecUnit import rvOpsPkg::*; (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   flush,
	input  logic                   issueValid,
	input  logic [`XLEN-1:0]       opA,
	input  logic [`XLEN-1:0]       opB,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic                   regWe,
	input  aluOp_t                 aluOp,
	input  mulOp_t                 mulOp,
	input  wbSel_t                 wbSel,
	input  logic [`XLEN-1:0]       uImm, // already shifted into place
	input  logic [`XLEN-1:0]       pc,
	intResIf.source                res
);

	logic                   valid5, regWe5;
	logic [`XLEN-1:0]       opA5, opB5, uImm5, pc5;
	logic [`REG_ADDR_W-1:0] rd5;
	aluOp_t                 aluOp5;
	mulOp_t                 mulOp5;
	wbSel_t                 wbSel5;

	logic [`XLEN-1:0]   aluRes, mulRes, selRes;
	logic [2*`XLEN-1:0] prodSs, prodUu;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			valid5    <= 1'b0;
			regWe5    <= 1'b0;
			res.valid <= 1'b0;
			res.regWe <= 1'b0;
		end
		else if (flush)
		begin
			// both stages become bubbles
			valid5    <= 1'b0;
			regWe5    <= 1'b0;
			res.valid <= 1'b0;
			res.regWe <= 1'b0;
		end
		else
		begin
			valid5    <= issueValid;
			regWe5    <= issueValid & regWe;
			res.valid <= valid5;
			res.regWe <= regWe5;
		end
	end

	always_ff @(posedge clk)
	begin
		opA5       <= opA;
		opB5       <= opB;
		rd5        <= rd;
		aluOp5     <= aluOp;
		mulOp5     <= mulOp;
		wbSel5     <= wbSel;
		uImm5      <= uImm;
		pc5        <= pc;
		res.result <= selRes;
		res.rd     <= rd5;
		res.isCsr  <= (wbSel5 == WB_CSR);
	end

	always_comb
	begin
		case (aluOp5)
			ALU_ADD:  aluRes = opA5 + opB5;
			ALU_SUB:  aluRes = opA5 - opB5;
			ALU_SLL:  aluRes = opA5 << opB5[4:0];
			ALU_SLT:  aluRes = {{(`XLEN-1){1'b0}}, $signed(opA5) < $signed(opB5)};
			ALU_SLTU: aluRes = {{(`XLEN-1){1'b0}}, opA5 < opB5};
			ALU_XOR:  aluRes = opA5 ^ opB5;
			ALU_SRL:  aluRes = opA5 >> opB5[4:0];
			ALU_SRA:  aluRes = $signed(opA5) >>> opB5[4:0];
			ALU_OR:   aluRes = opA5 | opB5;
			ALU_AND:  aluRes = opA5 & opB5;
			default:  aluRes = '0;
		endcase
	end

	// full products, low word is the same for both
	assign prodSs = {{`XLEN{opA5[`XLEN-1]}}, opA5} * {{`XLEN{opB5[`XLEN-1]}}, opB5};
	assign prodUu = {{`XLEN{1'b0}}, opA5} * {{`XLEN{1'b0}}, opB5};

	always_comb
	begin
		case (mulOp5)
			MUL_MUL:   mulRes = prodUu[`XLEN-1:0];
			MUL_MULH:  mulRes = prodSs[2*`XLEN-1:`XLEN];
			MUL_MULHU: mulRes = prodUu[2*`XLEN-1:`XLEN];
			default:   mulRes = '0;
		endcase
	end

	always_comb
	begin
		case (wbSel5)
			WB_ALU:   selRes = aluRes;
			WB_LINK:  selRes = pc5 + `XLEN'd4;
			WB_MUL:   selRes = mulRes;
			WB_LUI:   selRes = uImm5;
			WB_AUIPC: selRes = uImm5 + pc5;
			default:  selRes = '0; // csr value comes from the trap unit
		endcase
	end

endmodule

/* design/trapCsrUnit.sv */
`timescale 1ns/1ps
`include "exeSettings.svh"

module trapCsrUnit import rvOpsPkg::*, trapPkg::*; (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   flush,
	input  logic                   issueValid,
	input  csrOp_t                 csrOp,
	input  logic [`XLEN-1:0]       csrData,  // current csr value from the csr file
	input  logic [`REG_ADDR_W-1:0] csrImm,   // zimm from the rs1 field
	input  logic [`XLEN-1:0]       opA,
	input  logic [`CSR_ADDR_W-1:0] csrAddr,
	input  logic                   csrWe,
	input  logic                   ecall,
	input  logic                   illegalInstr,
	input  logic                   instrMisaligned,
	input  logic                   mret,
	input  logic [`XLEN-1:0]       pc,
	input  privMode_t              currentMode,
	input  logic                   mTimer, sTimer, mExt, sExt,
	input  logic                   mTie, sTie, mEie, sEie,
	trapResIf.source               res
);

	logic                   csrWe5, ecall5, illegal5, misaligned5, mret5;
	csrOp_t                 csrOp5;
	logic [`XLEN-1:0]       csrData5, opA5, pc5;
	logic [`REG_ADDR_W-1:0] csrImm5;
	logic [`CSR_ADDR_W-1:0] csrAddr5;
	logic [`XLEN-1:0]       csrSrc, csrNew5;

	logic ecall6, illegal6, misaligned6;
	logic mTimerOn, sTimerOn, mExtOn, sExtOn;
	logic sLevelOk;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			{csrWe5, ecall5, illegal5, misaligned5, mret5} <= '0;
			{res.csrWe, ecall6, illegal6, misaligned6, res.mret} <= '0;
		end
		else if (flush)
		begin
			// both stages become bubbles
			{csrWe5, ecall5, illegal5, misaligned5, mret5} <= '0;
			{res.csrWe, ecall6, illegal6, misaligned6, res.mret} <= '0;
		end
		else
		begin
			csrWe5      <= issueValid & csrWe;
			ecall5      <= issueValid & ecall;
			illegal5    <= issueValid & illegalInstr;
			misaligned5 <= issueValid & instrMisaligned;
			mret5       <= issueValid & mret;
			res.csrWe   <= csrWe5;
			ecall6      <= ecall5;
			illegal6    <= illegal5;
			misaligned6 <= misaligned5;
			res.mret    <= mret5;
		end
	end

	always_ff @(posedge clk)
	begin
		csrOp5      <= csrOp;
		csrData5    <= csrData;
		csrImm5     <= csrImm;
		opA5        <= opA;
		csrAddr5    <= csrAddr;
		pc5         <= pc;
		res.csrOld  <= csrData5; // old value goes to rd
		res.csrNew  <= csrNew5;
		res.csrAddr <= csrAddr5;
		res.pc      <= pc5;
	end

	// immediate forms take the zero-extended zimm
	assign csrSrc = (csrOp5 inside {CSR_RWI, CSR_RSI, CSR_RCI}) ?
		{{(`XLEN-`REG_ADDR_W){1'b0}}, csrImm5} : opA5;

	always_comb
	begin
		case (csrOp5)
			CSR_RW, CSR_RWI: csrNew5 = csrSrc;
			CSR_RS, CSR_RSI: csrNew5 = csrData5 | csrSrc;
			CSR_RC, CSR_RCI: csrNew5 = csrData5 & ~csrSrc;
			default:         csrNew5 = csrData5;
		endcase
	end

	// live interrupt gating with S level only below M
	assign sLevelOk = (currentMode <= PRIV_S);
	assign mExtOn   = mEie & mExt;
	assign sExtOn   = sLevelOk & sEie & sExt;
	assign mTimerOn = mTie & mTimer;
	assign sTimerOn = sLevelOk & sTie & sTimer;

	assign res.trapReq = mExtOn | sExtOn | mTimerOn | sTimerOn |
		misaligned6 | ecall6 | illegal6;

	always_comb
	begin
		res.cause.raw = '0;
		if (mExtOn)
			res.cause.f = '{intr: 1'b1, code: M_INT_EXT};
		else if (sExtOn)
			res.cause.f = '{intr: 1'b1, code: S_INT_EXT};
		else if (mTimerOn)
			res.cause.f = '{intr: 1'b1, code: M_INT_TIMER};
		else if (sTimerOn)
			res.cause.f = '{intr: 1'b1, code: S_INT_TIMER};
		else if (misaligned6)
			res.cause.f.code = I_ADDR_MISALIGNED;
		else if (ecall6)
			res.cause.f.code = excCode_t'(U_CALL + {{(`XLEN-3){1'b0}}, currentMode});
		else if (illegal6)
			res.cause.f.code = I_ILLEGAL;
	end

endmodule

/* design/commitSelect.sv */
`timescale 1ns/1ps
`include "exeSettings.svh"

module commitSelect (
	intResIf.sink                  intRes,
	trapResIf.sink                 trapRes,
	output logic                   flush,
	output logic [`XLEN-1:0]       wbData,
	output logic [`REG_ADDR_W-1:0] wbRd,
	output logic                   wbWe,
	output logic [`XLEN-1:0]       csrWbData,
	output logic [`CSR_ADDR_W-1:0] csrWbAddr,
	output logic                   csrWbWe,
	output logic                   trapTaken,
	output logic [`XLEN-1:0]       trapCause,
	output logic [`XLEN-1:0]       trapPc,
	output logic                   mretTaken
);

	logic commitOk;

	// any redirect empties both pipelines for one cycle
	assign flush = trapRes.trapReq | trapRes.mret;

	// stage-6 instruction retires only without a redirect
	assign commitOk = intRes.valid & ~flush;

	// csr instructions write the old value to rd
	assign wbData = intRes.isCsr ? trapRes.csrOld : intRes.result;
	assign wbRd   = intRes.rd;
	assign wbWe   = commitOk & intRes.regWe;

	assign csrWbData = trapRes.csrNew;
	assign csrWbAddr = trapRes.csrAddr;
	assign csrWbWe   = commitOk & trapRes.csrWe;

	assign trapTaken = trapRes.trapReq;
	assign trapCause = trapRes.cause.raw;
	assign trapPc    = trapRes.pc;    // becomes mepc
	assign mretTaken = trapRes.mret;

endmodule

/* design/exeStage.sv */
`timescale 1ns/1ps
`include "exeSettings.svh"

module exeStage import rvOpsPkg::*, trapPkg::*; (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   issueValid,
	input  logic [`XLEN-1:0]       opA,
	input  logic [`XLEN-1:0]       opB,
	input  logic [`REG_ADDR_W-1:0] rd,
	input  logic                   regWe,
	input  aluOp_t                 aluOp,
	input  mulOp_t                 mulOp,
	input  wbSel_t                 wbSel,
	input  logic [`XLEN-1:0]       uImm,
	input  logic [`XLEN-1:0]       pc,
	input  csrOp_t                 csrOp,
	input  logic [`XLEN-1:0]       csrData,
	input  logic [`REG_ADDR_W-1:0] csrImm,
	input  logic [`CSR_ADDR_W-1:0] csrAddr,
	input  logic                   csrWe,
	input  logic                   ecall,
	input  logic                   illegalInstr,
	input  logic                   instrMisaligned,
	input  logic                   mret,
	input  privMode_t              currentMode,
	input  logic                   mTimer, sTimer, mExt, sExt,
	input  logic                   mTie, sTie, mEie, sEie,
	output logic [`XLEN-1:0]       wbData,
	output logic [`REG_ADDR_W-1:0] wbRd,
	output logic                   wbWe,
	output logic [`XLEN-1:0]       csrWbData,
	output logic [`CSR_ADDR_W-1:0] csrWbAddr,
	output logic                   csrWbWe,
	output logic                   trapTaken,
	output logic [`XLEN-1:0]       trapCause,
	output logic [`XLEN-1:0]       trapPc,
	output logic                   mretTaken
);

	logic flush; // from commit back into both units

	intResIf  intRes ();
	trapResIf trapRes ();

	intExecUnit intExec (.*, .res(intRes));

	trapCsrUnit trapCsr (.*, .res(trapRes));

	commitSelect commitSel (
		.intRes  (intRes),
		.trapRes (trapRes),
		.*
	);

endmodule

/* test/exeVectors.svh */
`ifndef EXE_VECTORS_SVH
`define EXE_VECTORS_SVH

// row name plus the DUT inputs and expected results in vec_t
task automatic pushVec(string n, vec_t v);
	v.rd = 5'(vecs.size() % 31 + 1); // never x0
	names.push_back(n);
	vecs.push_back(v);
endtask

// rnd set means opA/opB come from the seeded generator
task automatic intRow(string n, aluOp_t a, mulOp_t m, wbSel_t w, bit rnd,
	logic [31:0] x, logic [31:0] y, logic [31:0] imm, logic [31:0] exp);
	vec_t v;
	v = '0;
	{v.issue, v.regWe, v.expWe} = 3'b111;
	v.aluOp = a;
	v.mulOp = m;
	v.wbSel = w;
	v.rnd = rnd;
	v.pc = basePc;
	{v.opA, v.opB, v.uImm, v.expData} = {x, y, imm, exp};
	pushVec(n, v);
endtask

task automatic csrRow(string n, csrOp_t c, logic [31:0] old, logic [31:0] src,
	logic [4:0] zimm, logic [31:0] expNew);
	vec_t v;
	v = '0;
	{v.issue, v.regWe, v.csrWe, v.expWe, v.expCsrWe} = 5'b11111;
	v.wbSel = WB_CSR;
	v.csrOp = c;
	{v.csrData, v.opA, v.csrImm} = {old, src, zimm};
	v.csrAddr = 12'h340 + 12'(vecs.size()); // distinct per row
	v.pc = basePc;
	{v.expData, v.expCsr} = {old, expNew}; // rd gets the old value
	pushVec(n, v);
endtask

// flags are {ecall, illegal, misaligned, mret}
// irq is {mTimer, sTimer, mExt, sExt, mTie, sTie, mEie, sEie}
task automatic trapRow(string n, logic [3:0] fl, privMode_t md, logic [7:0] irq,
	bit trap, logic [31:0] cause, bit mretExp);
	vec_t v;
	v = '0;
	{v.issue, v.regWe} = {|fl, |fl};
	v.flags = fl;
	v.mode = md;
	v.irq = irq;
	v.pc = 32'h0000_1000 + 32'(vecs.size() * 4); // distinct per row
	{v.expTrap, v.expCause, v.expMret} = {trap, cause, mretExp};
	pushVec(n, v);
endtask

task automatic markPair();
	vecs[vecs.size()-1].pairNext = 1'b1; // next row issues one cycle later
endtask

task automatic loadVectors();
	intRow("add", ALU_ADD, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("sub", ALU_SUB, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("sll", ALU_SLL, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("slt", ALU_SLT, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("sltNeg", ALU_SLT, MUL_NONE, WB_ALU, 0, 32'hffff_fff0, 32'h5, 0, 32'h1);
	intRow("sltu", ALU_SLTU, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("xor", ALU_XOR, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("srl", ALU_SRL, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("sra", ALU_SRA, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("or", ALU_OR, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("and", ALU_AND, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	intRow("mul", ALU_ADD, MUL_MUL, WB_MUL, 1, 0, 0, 0, 0);
	intRow("mulh", ALU_ADD, MUL_MULH, WB_MUL, 1, 0, 0, 0, 0);
	intRow("mulhu", ALU_ADD, MUL_MULHU, WB_MUL, 1, 0, 0, 0, 0);
	intRow("lui", ALU_ADD, MUL_NONE, WB_LUI, 0, 0, 0, 32'h1234_5000, 32'h1234_5000);
	intRow("auipc", ALU_ADD, MUL_NONE, WB_AUIPC, 0, 0, 0, 32'h1234_5000, 32'h1234_5800);
	intRow("link", ALU_ADD, MUL_NONE, WB_LINK, 0, 0, 0, 0, 32'h0000_0804);
	csrRow("csrrw", CSR_RW, 32'h0f0, 32'hf0f, 5'h13, 32'hf0f);
	csrRow("csrrs", CSR_RS, 32'h0f0, 32'hf0f, 5'h13, 32'hfff);
	csrRow("csrrc", CSR_RC, 32'h0f0, 32'hf0f, 5'h13, 32'h0f0);
	csrRow("csrrwi", CSR_RWI, 32'h0f0, 32'hf0f, 5'h13, 32'h013);
	csrRow("csrrsi", CSR_RSI, 32'h0f0, 32'hf0f, 5'h13, 32'h0f3);
	csrRow("csrrci", CSR_RCI, 32'h0f0, 32'hf0f, 5'h13, 32'h0e0);
	trapRow("ecallU", 4'b1000, PRIV_U, 8'h00, 1, 32'd8, 0);
	trapRow("ecallS", 4'b1000, PRIV_S, 8'h00, 1, 32'd9, 0);
	trapRow("ecallM", 4'b1000, PRIV_M, 8'h00, 1, 32'd11, 0);
	trapRow("illegal", 4'b0100, PRIV_M, 8'h00, 1, 32'd2, 0);
	trapRow("misaligned", 4'b0010, PRIV_M, 8'h00, 1, 32'd0, 0);
	trapRow("mret", 4'b0001, PRIV_M, 8'h00, 0, 32'd0, 1);
	trapRow("mExtInt", 4'b0000, PRIV_M, 8'b0010_0010, 1, 32'h8000_000b, 0);
	trapRow("sExtInt", 4'b0000, PRIV_S, 8'b0001_0001, 1, 32'h8000_0009, 0);
	trapRow("mTimerInt", 4'b0000, PRIV_U, 8'b1000_1000, 1, 32'h8000_0007, 0);
	trapRow("sTimerInt", 4'b0000, PRIV_S, 8'b0100_0100, 1, 32'h8000_0005, 0);
	trapRow("allPending", 4'b0000, PRIV_U, 8'b1111_1111, 1, 32'h8000_000b, 0);
	trapRow("noMExt", 4'b0000, PRIV_S, 8'b1101_1101, 1, 32'h8000_0009, 0);
	trapRow("sIntInM", 4'b0000, PRIV_M, 8'b0101_0101, 0, 32'd0, 0);
	trapRow("intDisabled", 4'b0000, PRIV_U, 8'b1111_0000, 0, 32'd0, 0);
	intRow("pairFirst", ALU_ADD, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	markPair();
	intRow("pairSecond", ALU_SUB, MUL_NONE, WB_ALU, 1, 0, 0, 0, 0);
	trapRow("ecallPair", 4'b1000, PRIV_U, 8'h00, 1, 32'd8, 0);
	markPair();
	intRow("flushedAdd", ALU_ADD, MUL_NONE, WB_ALU, 0, 32'd5, 32'd6, 0, 32'd11);
	vecs[vecs.size()-1].expWe = 1'b0; // lost behind the ecall
endtask

`endif

/* test/exeStageTb.sv */
`timescale 1ns/1ps
`include "exeSettings.svh"

module exeStageTb import rvOpsPkg::*, trapPkg::*; ;

	typedef struct packed {
		logic pairNext, rnd, issue, regWe, csrWe;
		logic [4:0] rd;
		aluOp_t aluOp;
		mulOp_t mulOp;
		wbSel_t wbSel;
		csrOp_t csrOp;
		logic [31:0] opA, opB, uImm, csrData, pc;
		logic [11:0] csrAddr;
		logic [4:0] csrImm;
		logic [3:0] flags;
		privMode_t mode;
		logic [7:0] irq;
		logic [31:0] expData, expCsr;
		logic expWe, expCsrWe, expTrap, expMret;
		cause_t expCause;
	} vec_t;

	localparam logic [31:0] basePc = 32'h0000_0800;

	vec_t vecs[$];
	string names[$];
	integer seed;
	int cycles, limit;

	logic clk, nrst, issueValid, regWe, csrWe, ecall, illegalInstr, instrMisaligned, mret;
	logic [31:0] opA, opB, uImm, pc, csrData;
	logic [4:0] rd, csrImm;
	logic [11:0] csrAddr;
	aluOp_t aluOp;
	mulOp_t mulOp;
	wbSel_t wbSel;
	csrOp_t csrOp;
	privMode_t currentMode;
	logic mTimer, sTimer, mExt, sExt, mTie, sTie, mEie, sEie;
	logic [31:0] wbData, csrWbData, trapCause, trapPc;
	logic [4:0] wbRd;
	logic [11:0] csrWbAddr;
	logic wbWe, csrWbWe, trapTaken, mretTaken;

	`include "exeVectors.svh"

	exeStage dut_i (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: no result after %0d cycles", limit);
			$display("test failed");
			$fatal(1);
		end
	end

	task automatic checkWord(string n, string what, logic [31:0] exp, logic [31:0] act);
		if (act !== exp)
		begin
			$display("FAIL %s %s: expected %h, actual %h", n, what, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic checkCause(string n, cause_t exp, cause_t act);
		if (act !== exp)
		begin
			$display("FAIL %s cause: expected %h, actual %h", n, exp.raw, act.raw);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(string n, string what, logic exp, logic act);
		if (act !== exp)
		begin
			$display("FAIL %s %s: expected %b, actual %b", n, what, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// reference integer results from the ISA definitions
	function automatic logic [31:0] refInt(vec_t v);
		logic [63:0] pu, ps, ext;
		logic [4:0] sh;
		pu = {32'b0, v.opA} * {32'b0, v.opB};
		ps = longint'($signed(v.opA)) * longint'($signed(v.opB));
		sh = v.opB[4:0];
		ext = {{32{v.opA[31]}}, v.opA} >> sh; // sign fill for sra
		if (v.wbSel == WB_MUL)
		begin
			case (v.mulOp)
				MUL_MUL:  return pu[31:0];
				MUL_MULH: return ps[63:32];
				default:  return pu[63:32];
			endcase
		end
		case (v.aluOp)
			ALU_ADD:  return v.opA + v.opB;
			ALU_SUB:  return v.opA - v.opB;
			ALU_SLL:  return v.opA << sh;
			ALU_SLT:  return {31'b0, $signed(v.opA) < $signed(v.opB)};
			ALU_SLTU: return {31'b0, v.opA < v.opB};
			ALU_XOR:  return v.opA ^ v.opB;
			ALU_SRL:  return v.opA >> sh;
			ALU_SRA:  return ext[31:0];
			ALU_OR:   return v.opA | v.opB;
			default:  return v.opA & v.opB;
		endcase
	endfunction

	function automatic vec_t prepare(vec_t v);
		if (v.rnd)
		begin
			v.opA = $random(seed);
			v.opB = $random(seed);
			v.expData = refInt(v);
		end
		return v;
	endfunction

	task automatic driveRow(vec_t v);
		{issueValid, regWe, csrWe, rd} = {v.issue, v.regWe, v.csrWe, v.rd};
		aluOp = v.aluOp;
		mulOp = v.mulOp;
		wbSel = v.wbSel;
		csrOp = v.csrOp;
		{opA, opB, uImm, csrData, csrImm} = {v.opA, v.opB, v.uImm, v.csrData, v.csrImm};
		pc = v.pc;
		csrAddr = v.csrAddr;
		{ecall, illegalInstr, instrMisaligned, mret} = v.flags;
		currentMode = v.mode;
		{mTimer, sTimer, mExt, sExt, mTie, sTie, mEie, sEie} = v.irq;
	endtask

	task automatic checkRow(string n, vec_t v);
		checkFlag(n, "wbWe", v.expWe, wbWe);
		if (v.expWe)
		begin
			checkWord(n, "wbData", v.expData, wbData);
			checkWord(n, "wbRd", 32'(v.rd), 32'(wbRd));
		end
		checkFlag(n, "csrWbWe", v.expCsrWe, csrWbWe);
		if (v.expCsrWe)
		begin
			checkWord(n, "csrWbData", v.expCsr, csrWbData);
			checkWord(n, "csrWbAddr", 32'(v.csrAddr), 32'(csrWbAddr));
		end
		checkFlag(n, "trapTaken", v.expTrap, trapTaken);
		if (v.expTrap)
		begin
			checkCause(n, v.expCause, cause_t'(trapCause));
			if (v.issue)
				checkWord(n, "trapPc", v.pc, trapPc); // pc of the trapping instruction
		end
		checkFlag(n, "mretTaken", v.expMret, mretTaken);
	endtask

	initial
	begin
		vec_t a, b;
		int i;
		seed = 32'hd0d8_ebc8;
		cycles = 0;
		loadVectors();
		limit = vecs.size() * 6 + 20;
		driveRow('0);
		nrst = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk) nrst = 1'b1;
		i = 0;
		while (i < vecs.size())
		begin
			a = prepare(vecs[i]);
			driveRow(a);
			@(posedge clk);
			@(negedge clk);
			if (a.pairNext)
			begin
				b = prepare(vecs[i+1]);
				driveRow(b); // second one right behind
				@(posedge clk);
				@(negedge clk);
				checkRow(names[i], a);
				issueValid = 1'b0;
				@(posedge clk);
				@(negedge clk);
				checkRow(names[i+1], b);
				i += 2;
			end
			else
			begin
				issueValid = 1'b0;
				@(posedge clk);
				@(negedge clk);
				checkRow(names[i], a);
				i += 1;
			end
			driveRow('0); // one idle cycle lets any flush drain
			@(posedge clk);
			@(negedge clk);
		end
		$display("test passed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+design
+incdir+test
design/rvOpsPkg.sv
design/trapPkg.sv
design/exeIfs.sv
design/intExecUnit.sv
design/trapCsrUnit.sv
design/commitSelect.sv
design/exeStage.sv
test/exeStageTb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module exeStageTb -Mdir obj_dir \
	-f verilog.f > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/VexeStageTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
